//--- enigma.f
+incdir+hdl
hdl/enigmaPkg.sv
hdl/letterCodec.sv
hdl/rotorWheel.sv
hdl/rotorStepper.sv
hdl/scramblerPath.sv
hdl/enigmaTop.sv
tb/enigmaTb.sv

//--- hdl/enigmaPkg.sv
// Field widths are written out by hand and must track the macros of the config header
package enigmaPkg;

    // Bit i set means letter 'A' + i
    typedef logic [25:0] oneHotLetter;

    // Only 0 to 25 are legal
    typedef logic [4:0] rotorPos;

    // Right rotor steps on every letter
    typedef struct packed {
        rotorPos right;
        rotorPos middle;
        rotorPos left;
    } rotorSet;

    typedef struct packed {
        logic       valid;
        logic [7:0] ascii;
    } charStream;

endpackage

//--- hdl/enigmaTop.sv
// No back-pressure so every accepted character leaves exactly one cycle later and nothing is held
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module enigmaTop import enigmaPkg::*; (
    input  logic      load,
    input  logic      reset,
    input  logic      setKey,
    input  rotorSet   startPos,
    input  charStream charIn,
    output charStream charOut,
    output rotorSet   positions
);

    logic                   isLetter;
    logic                   advance;
    oneHotLetter            plainLetter;
    oneHotLetter            cipherLetter;
    logic [`CHAR_WIDTH-1:0] cipherByte;

    letterCodec codec (
        .asciiIn   (charIn.ascii),
        .isLetter  (isLetter),
        .letterOut (plainLetter),
        .letterIn  (cipherLetter),
        .asciiOut  (cipherByte)
    );

    // Enciphers with the positions of this cycle
    scramblerPath path (
        .positions (positions),
        .letterIn  (plainLetter),
        .letterOut (cipherLetter)
    );

    // A key load in the same cycle suppresses the step
    assign advance = charIn.valid && isLetter && !setKey;

    rotorStepper stepper (
        .load      (load),
        .reset     (reset),
        .setKey    (setKey),
        .startPos  (startPos),
        .advance   (advance),
        .positions (positions)
    );

    always_ff @(posedge load) begin
        if (charIn.valid) begin
            // Non-letters go out untouched
            charOut.ascii <= isLetter ? cipherByte : charIn.ascii;
        end
        if (reset) begin
            charOut.valid <= 1'b0;
        end else begin
            charOut.valid <= charIn.valid;
        end
    end

endmodule

//--- hdl/enigma_cfg.svh
// Wiring tables are fixed at build time and the package widths must be kept in step by hand
`ifndef ENIGMA_CFG_SVH
`define ENIGMA_CFG_SVH

`define ALPHABET_SIZE 26
`define POS_WIDTH 5
`define CHAR_WIDTH 8

// Entry i is the contact that contact i feeds going toward the reflector
`define ROTOR1_WIRING '{ \
    5'd7,  5'd12, 5'd21, 5'd17, 5'd0,  5'd2,  5'd22, \
    5'd20, 5'd23, 5'd18, 5'd9,  5'd25, 5'd15, 5'd3, \
    5'd14, 5'd13, 5'd11, 5'd8,  5'd4,  5'd10, 5'd6, \
    5'd5,  5'd19, 5'd16, 5'd24, 5'd1}

`define ROTOR2_WIRING '{ \
    5'd19, 5'd4,  5'd7,  5'd6,  5'd12, 5'd17, 5'd8, \
    5'd5,  5'd2,  5'd0,  5'd1,  5'd20, 5'd25, 5'd9, \
    5'd14, 5'd22, 5'd24, 5'd18, 5'd15, 5'd13, 5'd3, \
    5'd10, 5'd21, 5'd16, 5'd11, 5'd23}

`define ROTOR3_WIRING '{ \
    5'd19, 5'd0,  5'd6,  5'd1,  5'd15, 5'd2,  5'd18, \
    5'd3,  5'd16, 5'd4,  5'd20, 5'd5,  5'd21, 5'd13, \
    5'd25, 5'd7,  5'd24, 5'd8,  5'd23, 5'd9,  5'd22, \
    5'd11, 5'd17, 5'd10, 5'd14, 5'd12}

// S maps to itself on the plugboard
`define PLUG_WIRING '{ \
    5'd4,  5'd10, 5'd12, 5'd5,  5'd11, 5'd6,  5'd3, \
    5'd16, 5'd21, 5'd25, 5'd13, 5'd19, 5'd14, 5'd22, \
    5'd24, 5'd7,  5'd23, 5'd20, 5'd18, 5'd15, 5'd0, \
    5'd8,  5'd1,  5'd17, 5'd2,  5'd9}

// Pairs swap and no letter maps to itself
`define REFLECT_WIRING '{ \
    5'd24, 5'd17, 5'd20, 5'd7,  5'd16, 5'd18, 5'd11, \
    5'd3,  5'd15, 5'd23, 5'd13, 5'd6,  5'd14, 5'd10, \
    5'd12, 5'd8,  5'd4,  5'd1,  5'd5,  5'd25, 5'd2, \
    5'd22, 5'd21, 5'd9,  5'd0,  5'd19}

`endif

//--- hdl/letterCodec.sv
// Only uppercase A to Z count as letters and lowercase bytes are treated as non-letters
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module letterCodec import enigmaPkg::*; (
    input  logic [`CHAR_WIDTH-1:0] asciiIn,
    output logic                   isLetter,
    output oneHotLetter            letterOut,
    input  oneHotLetter            letterIn,
    output logic [`CHAR_WIDTH-1:0] asciiOut
);

    // ASCII to one-hot
    always_comb begin
        isLetter  = (asciiIn >= "A") && (asciiIn <= "Z");
        letterOut = '0;
        if (isLetter) begin
            letterOut = oneHotLetter'(1) << (asciiIn - "A");
        end
    end

    // One-hot back to ASCII
    always_comb begin
        // Empty letter reads as '?'
        asciiOut = "?";
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            if (letterIn[i]) begin
                asciiOut = "A" + i[`CHAR_WIDTH-1:0];
            end
        end
    end

    // Encoder expects at most one letter bit set
    always_comb begin
        if (letterIn != '0) begin
            assert ($onehot(letterIn))
                else $error("letterCodec: letter input %b is not one-hot", letterIn);
        end
    end

endmodule

//--- hdl/rotorStepper.sv
// startPos fields must be below 26 while setKey is high and setKey takes priority over advance
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module rotorStepper import enigmaPkg::*; (
    input  logic    load,
    input  logic    reset,
    input  logic    setKey,
    input  rotorSet startPos,
    input  logic    advance,
    output rotorSet positions
);

    logic rightWrap;
    logic middleWrap;

    function automatic rotorPos nextPos(rotorPos p);
        return (p == rotorPos'(`ALPHABET_SIZE - 1)) ? '0 : p + 1'b1;
    endfunction

    // Carries out of the faster rotors
    assign rightWrap  = positions.right == rotorPos'(`ALPHABET_SIZE - 1);
    assign middleWrap = positions.middle == rotorPos'(`ALPHABET_SIZE - 1);

    always_ff @(posedge load) begin
        if (reset) begin
            positions <= '0;
        end else if (setKey) begin
            positions <= startPos;
        end else if (advance) begin
            positions.right <= nextPos(positions.right);
            if (rightWrap) begin
                positions.middle <= nextPos(positions.middle);
            end
            // Double carry turns the left rotor
            if (rightWrap && middleWrap) begin
                positions.left <= nextPos(positions.left);
            end
        end
    end

    positionsInRange: assert property (@(posedge load) disable iff (reset)
        (positions.right < `ALPHABET_SIZE) &&
        (positions.middle < `ALPHABET_SIZE) &&
        (positions.left < `ALPHABET_SIZE))
        else $error("rotorStepper: position out of range %p", positions);

    startPosInRange: assert property (@(posedge load) disable iff (reset)
        setKey |-> (startPos.right < `ALPHABET_SIZE) &&
                   (startPos.middle < `ALPHABET_SIZE) &&
                   (startPos.left < `ALPHABET_SIZE))
        else $error("rotorStepper: bad start key %p", startPos);

endmodule

//--- hdl/rotorWheel.sv
// Position must stay below 26 or the rotation stops keeping letters one-hot
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module rotorWheel import enigmaPkg::*; #(
    parameter logic [`POS_WIDTH-1:0] wiring [`ALPHABET_SIZE] = `ROTOR1_WIRING
) (
    input  rotorPos     position,
    input  oneHotLetter forwardIn,
    output oneHotLetter forwardOut,
    input  oneHotLetter backwardIn,
    output oneHotLetter backwardOut
);

    oneHotLetter fwdAligned;
    oneHotLetter fwdWired;
    oneHotLetter bwdAligned;
    oneHotLetter bwdWired;

    // Bit k takes bit k + amount, wrapping at 26
    function automatic oneHotLetter rotateRight(oneHotLetter x, rotorPos amount);
        logic [2*`ALPHABET_SIZE-1:0] doubled;
        doubled = {x, x} >> amount;
        return doubled[`ALPHABET_SIZE-1:0];
    endfunction

    function automatic oneHotLetter rotateLeft(oneHotLetter x, rotorPos amount);
        logic [2*`ALPHABET_SIZE-1:0] doubled;
        doubled = {x, x} << amount;
        return doubled[2*`ALPHABET_SIZE-1:`ALPHABET_SIZE];
    endfunction

    assign fwdAligned = rotateRight(forwardIn, position);
    assign bwdAligned = rotateRight(backwardIn, position);

    // Same table read both ways, so the backward path undoes the forward one
    always_comb begin
        fwdWired = '0;
        bwdWired = '0;
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            fwdWired[wiring[i]] = fwdAligned[i];
            bwdWired[i]         = bwdAligned[wiring[i]];
        end
    end

    // Undo the alignment shift
    assign forwardOut  = rotateLeft(fwdWired, position);
    assign backwardOut = rotateLeft(bwdWired, position);

    always_comb begin
        if ($onehot(forwardIn)) begin
            assert ($onehot(forwardOut))
                else $error("rotorWheel: forward lost one-hot at position %0d", position);
        end
        if ($onehot(backwardIn)) begin
            assert ($onehot(backwardOut))
                else $error("rotorWheel: backward lost one-hot at position %0d", position);
        end
    end

endmodule

//--- hdl/scramblerPath.sv
// Purely combinational and the result only means something for a one-hot input letter
`timescale 1ns/1ps
`include "enigma_cfg.svh"

module scramblerPath import enigmaPkg::*; (
    input  rotorSet     positions,
    input  oneHotLetter letterIn,
    output oneHotLetter letterOut
);

    localparam logic [`POS_WIDTH-1:0] plugWiring [`ALPHABET_SIZE] = `PLUG_WIRING;
    localparam logic [`POS_WIDTH-1:0] reflectWiring [`ALPHABET_SIZE] = `REFLECT_WIRING;

    oneHotLetter plugFwd;
    oneHotLetter rightFwd;
    oneHotLetter middleFwd;
    oneHotLetter leftFwd;
    oneHotLetter reflected;
    oneHotLetter leftBwd;
    oneHotLetter middleBwd;
    oneHotLetter rightBwd;

    // Plugboard toward the rotors
    always_comb begin
        plugFwd = '0;
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            plugFwd[plugWiring[i]] = letterIn[i];
        end
    end

    rotorWheel #(.wiring(`ROTOR1_WIRING)) rightRotor (
        .position    (positions.right),
        .forwardIn   (plugFwd),
        .forwardOut  (rightFwd),
        .backwardIn  (middleBwd),
        .backwardOut (rightBwd)
    );

    rotorWheel #(.wiring(`ROTOR2_WIRING)) middleRotor (
        .position    (positions.middle),
        .forwardIn   (rightFwd),
        .forwardOut  (middleFwd),
        .backwardIn  (leftBwd),
        .backwardOut (middleBwd)
    );

    rotorWheel #(.wiring(`ROTOR3_WIRING)) leftRotor (
        .position    (positions.left),
        .forwardIn   (middleFwd),
        .forwardOut  (leftFwd),
        .backwardIn  (reflected),
        .backwardOut (leftBwd)
    );

    // Reflector turns the signal back through the rotors
    always_comb begin
        reflected = '0;
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            reflected[reflectWiring[i]] = leftFwd[i];
        end
    end

    // Plugboard again in reverse
    always_comb begin
        letterOut = '0;
        for (int i = 0; i < `ALPHABET_SIZE; i++) begin
            letterOut[i] = rightBwd[plugWiring[i]];
        end
    end

    always_comb begin
        if ($onehot(letterIn)) begin
            assert ($onehot(letterOut) && (letterOut != letterIn))
                else $error("scramblerPath: %b enciphered to %b", letterIn, letterOut);
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the Enigma testbench with Verilator, run it and look for the pass message.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module enigmaTb -f enigma.f \
    && ./obj_dir/VenigmaTb | tee /dev/stderr | grep "^NO ERRORS$" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- tb/enigmaTb.sv
// Assumes one cycle of latency and no back-pressure, and treats only uppercase A to Z as letters
`timescale 1ns/1ps

module enigmaTb import enigmaPkg::*; ();

    localparam int waitLimit = 20;
    localparam logic [7:0] oddBytes [8] = '{"a", " ", "0", "z", 8'h00, 8'hff, "@", "["};

    logic      load;
    logic      reset;
    logic      setKey;
    rotorSet   startPos;
    charStream charIn;
    charStream charOut;
    rotorSet   positions;

    // Reference state for the checks
    rotorSet    modelPos;
    charStream  lastIn;
    logic       replyCheck;
    logic [7:0] replyPlain;
    logic       lastReplyCheck;
    logic [7:0] lastReplyPlain;
    logic       recordOn;
    logic [7:0] cipherQ [$];
    logic [7:0] message [$];
    int         valueErrors = 0;
    int         otherErrors = 0;

    enigmaTop UUT (
        .load      (load),
        .reset     (reset),
        .setKey    (setKey),
        .startPos  (startPos),
        .charIn    (charIn),
        .charOut   (charOut),
        .positions (positions)
    );

    always #2 load = ~load;

    function automatic logic isUpper(logic [7:0] b);
        return (b >= "A") && (b <= "Z");
    endfunction

    function automatic rotorPos wrapInc(rotorPos p);
        return (p == 5'd25) ? 5'd0 : p + 5'd1;
    endfunction

    // Odometer rule for one accepted letter
    function automatic rotorSet stepOdometer(rotorSet p);
        rotorSet n;
        n = p;
        n.right = wrapInc(p.right);
        if (p.right == 5'd25) begin
            n.middle = wrapInc(p.middle);
        end
        if ((p.right == 5'd25) && (p.middle == 5'd25)) begin
            n.left = wrapInc(p.left);
        end
        return n;
    endfunction

    function automatic rotorSet keyOf(rotorPos r, rotorPos m, rotorPos l);
        rotorSet k;
        k.right  = r;
        k.middle = m;
        k.left   = l;
        return k;
    endfunction

    function automatic rotorSet randomKey();
        return keyOf(rotorPos'($urandom_range(25, 0)), rotorPos'($urandom_range(25, 0)),
                     rotorPos'($urandom_range(25, 0)));
    endfunction

    function automatic logic [7:0] randomLetter();
        return 8'("A" + $urandom_range(25, 0));
    endfunction

    always @(posedge load) begin
        lastIn         <= charIn;
        lastReplyCheck <= replyCheck;
        lastReplyPlain <= replyPlain;
        if (reset) begin
            modelPos <= '0;
        end else if (setKey) begin
            modelPos <= startPos;
        end else if (charIn.valid && isUpper(charIn.ascii)) begin
            modelPos <= stepOdometer(modelPos);
        end
    end

    // Output is stable at the falling edge
    always @(negedge load) begin
        if (recordOn && charOut.valid) begin
            cipherQ.push_back(charOut.ascii);
        end
    end

    resetClears: assert property (@(posedge load) reset |=> (!charOut.valid && positions == '0))
        else begin
            valueErrors++;
            $display("[ERROR] reset: expected valid 0 pos 0/0/0, actual valid %0b pos %0d/%0d/%0d",
                     $sampled(charOut.valid), $sampled(positions.right),
                     $sampled(positions.middle), $sampled(positions.left));
        end

    validFollows: assert property (@(posedge load) disable iff (reset)
        charOut.valid == lastIn.valid)
        else begin
            valueErrors++;
            $display("[ERROR] latency: expected valid %0b, actual %0b",
                     $sampled(lastIn.valid), $sampled(charOut.valid));
        end

    positionsMatch: assert property (@(posedge load) disable iff (reset) positions == modelPos)
        else begin
            valueErrors++;
            $display("[ERROR] stepping: expected %0d/%0d/%0d, actual %0d/%0d/%0d",
                     $sampled(modelPos.right), $sampled(modelPos.middle), $sampled(modelPos.left),
                     $sampled(positions.right), $sampled(positions.middle),
                     $sampled(positions.left));
        end

    letterChanged: assert property (@(posedge load) disable iff (reset)
        (lastIn.valid && isUpper(lastIn.ascii)) |->
            (isUpper(charOut.ascii) && charOut.ascii != lastIn.ascii))
        else begin
            valueErrors++;
            $display("[ERROR] self-encryption: expected a letter other than %h, actual %h",
                     $sampled(lastIn.ascii), $sampled(charOut.ascii));
        end

    passthrough: assert property (@(posedge load) disable iff (reset)
        (lastIn.valid && !isUpper(lastIn.ascii)) |-> charOut.ascii == lastIn.ascii)
        else begin
            valueErrors++;
            $display("[ERROR] passthrough: expected %h, actual %h",
                     $sampled(lastIn.ascii), $sampled(charOut.ascii));
        end

    reciprocity: assert property (@(posedge load) disable iff (reset)
        lastReplyCheck |-> charOut.ascii == lastReplyPlain)
        else begin
            valueErrors++;
            $display("[ERROR] reciprocity: expected %h, actual %h",
                     $sampled(lastReplyPlain), $sampled(charOut.ascii));
        end

    task automatic idle(int cycles);
        charIn     <= '0;
        setKey     <= 1'b0;
        replyCheck <= 1'b0;
        repeat (cycles) @(posedge load);
    endtask

    task automatic sendChar(logic [7:0] b);
        charIn     <= {1'b1, b};
        setKey     <= 1'b0;
        replyCheck <= 1'b0;
        @(posedge load);
    endtask

    task automatic sendReply(logic [7:0] b, logic [7:0] plain);
        charIn     <= {1'b1, b};
        setKey     <= 1'b0;
        replyCheck <= 1'b1;
        replyPlain <= plain;
        @(posedge load);
    endtask

    // Key load with an optional letter in the same cycle
    task automatic loadKey(rotorSet k, logic withLetter);
        setKey     <= 1'b1;
        startPos   <= k;
        replyCheck <= 1'b0;
        charIn     <= withLetter ? {1'b1, randomLetter()} : '0;
        @(posedge load);
    endtask

    task automatic waitForCipher(int count, output logic ok);
        int waited;
        waited = 0;
        while ((cipherQ.size() < count) && (waited < waitLimit)) begin
            @(posedge load);
            waited++;
        end
        ok = cipherQ.size() >= count;
        if (!ok) begin
            otherErrors++;
            $display("Timed out: only %0d of %0d enciphered characters came back",
                     cipherQ.size(), count);
        end
    endtask

    initial begin
        int   msgLen;
        logic ok;
        rotorSet key;
        void'($urandom(32'hb6fb));
        load       = 1'b0;
        reset      = 1'b1;
        setKey     = 1'b0;
        startPos   = '0;
        charIn     = '0;
        replyCheck = 1'b0;
        replyPlain = '0;
        recordOn   = 1'b0;
        repeat (8) @(posedge load);
        reset <= 1'b0;
        idle(2);

        // Non-letters back to back without stepping
        for (int i = 0; i < 8; i++) begin
            sendChar(oddBytes[i]);
        end
        idle(1);

        // Double carry and left wrap
        loadKey(keyOf(5'd23, 5'd25, 5'd25), 1'b0);
        for (int i = 0; i < 6; i++) begin
            sendChar(randomLetter());
        end
        loadKey(keyOf(5'd24, 5'd25, 5'd3), 1'b1);
        for (int i = 0; i < 4; i++) begin
            sendChar(randomLetter());
            sendChar(oddBytes[i]);
        end
        loadKey(keyOf(5'd25, 5'd24, 5'd0), 1'b0);
        for (int i = 0; i < 30; i++) begin
            sendChar(randomLetter());
        end
        idle(2);

        // Mixed random stream with gaps
        loadKey(randomKey(), 1'b0);
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(3, 0) != 0) begin
                sendChar(randomLetter());
            end else begin
                sendChar(8'($urandom_range(255, 0)));
            end
            if ($urandom_range(7, 0) == 0) begin
                idle(1);
            end
        end
        idle(2);

        for (int round = 0; round < 3; round++) begin
            key    = randomKey();
            msgLen = $urandom_range(40, 20);
            message.delete();
            cipherQ.delete();
            for (int i = 0; i < msgLen; i++) begin
                message.push_back(randomLetter());
            end
            recordOn <= 1'b1;
            loadKey(key, 1'b0);
            for (int i = 0; i < msgLen; i++) begin
                sendChar(message[i]);
            end
            idle(0);
            waitForCipher(msgLen, ok);
            recordOn <= 1'b0;
            idle(2);
            if (ok) begin
                loadKey(key, 1'b0);
                for (int i = 0; i < msgLen; i++) begin
                    sendReply(cipherQ[i], message[i]);
                end
                idle(2);
            end
        end

        idle(4);
        $display("Checks finished with %0d value errors and %0d other errors",
                 valueErrors, otherErrors);
        if ((valueErrors == 0) && (otherErrors == 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
